/* verilog.f */
hdl/tile_pkg.sv
hdl/wb_arbiter.sv
hdl/wb_bus.sv
hdl/mam_wb_adapter.sv
hdl/wb_sram_sp.sv
hdl/bootrom.sv
hdl/compute_tile_dm.sv
verification/compute_tile_dm_asserts.sv
verification/tb_compute_tile_dm.sv

/* Makefile */
TOP = tb_compute_tile_dm

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module compute_tile_dm -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_compute_tile_dm.sv */
// ------------------------------
// Tile memory system testbench:
// stimulus, reference model,
// compare process and timeout
// ------------------------------
`timescale 1ns/1ps

module tb_compute_tile_dm;

   localparam int N_RAND = 40;   // Transfers per port, random test
   localparam int N_FAIR = 16;   // Rounds, fairness test
   localparam int TOTAL  = 32 + 17 + 5 + 3 * N_RAND + 3 * N_FAIR;
   localparam int LIMIT  = 20 * TOTAL + 200;

   logic                                         clk;
   logic                                         reset_i;
   tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] bus_req;
   tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] bus_rsp;
   tile_pkg::wb_req_t                            mam_req;
   tile_pkg::wb_rsp_t                            mam_rsp;

   tile_pkg::wb_req_t req [3];   // Instruction, data, debug
   logic [2:0]        busy;
   int                done_cnt [3];
   logic [31:0]       model_mem [tile_pkg::LMEM_WORDS];
   logic [3:0]        sel_pat [8] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'h5, 4'ha};
   logic              in_fair;
   logic              order [$];  // Master of each completion
   string             chk_name [$];
   logic [33:0]       chk_exp [$];
   logic [33:0]       chk_act [$];
   int                n_checks;
   int                n_errors;
   int                cycles;

   assign bus_req[0] = req[0];
   assign bus_req[1] = req[1];
   assign mam_req    = req[2];

   compute_tile_dm dut (
      .clk       (clk),
      .reset_i   (reset_i),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .mam_req_i (mam_req),
      .mam_rsp_o (mam_rsp)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Expected {ack, err, read data} from the address map
   function automatic logic [33:0] expect_read(input logic [31:0] adr, input logic we);
      if (adr[31:28] == tile_pkg::ROM_REGION) begin
         return we ? {2'b01, 32'h0} : {2'b10, tile_pkg::BOOT_IMAGE[adr[4:2]]};
      end
      if (!adr[31]) begin
         return we ? {2'b10, 32'h0} : {2'b10, model_mem[adr[9:2]]};
      end
      return {2'b01, 32'h0};                        // Network adapter and unmapped
   endfunction

   function automatic void apply_write(input logic [31:0] adr, input logic [3:0] sel,
                                       input logic [31:0] dat);
      if (!adr[31]) begin
         for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
               model_mem[adr[9:2]][8*b +: 8] = dat[8*b +: 8];
            end
         end
      end
   endfunction

   task automatic post_result(input string name, input logic [33:0] exp,
                              input logic [33:0] act);
      chk_name.push_back(name);
      chk_exp.push_back(exp);
      chk_act.push_back(act);
   endtask

   task automatic check_value(input string name, input logic [33:0] exp,
                              input logic [33:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // One classic cycle on port 0 (instruction), 1 (data) or 2 (debug)
   task automatic run_cycle(input logic [1:0] port, input logic we, input logic [3:0] sel,
                            input logic [31:0] adr, input logic [31:0] dat, input string name);
      tile_pkg::wb_rsp_t rsp;
      logic [33:0]       exp;
      @(posedge clk);
      #1;
      req[port]  = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
      busy[port] = 1'b1;
      do begin
         @(negedge clk);
         rsp = (port == 2'd2) ? mam_rsp : bus_rsp[port[0]];
      end while (!(rsp.ack || rsp.err));
      exp = expect_read(adr, we);
      if (rsp.ack && we) begin
         apply_write(adr, sel, dat);                // Model follows ack order
      end
      post_result(name, exp, {rsp.ack, rsp.err, (rsp.ack && !we) ? rsp.dat : 32'h0});
      done_cnt[port]++;
      if (in_fair && port != 2'd2) begin
         order.push_back(port[0]);
      end
      @(posedge clk);
      #1;
      req[port]  = '0;
      busy[port] = 1'b0;
   endtask

   task automatic random_traffic(input logic [1:0] port, input int count, input string tag);
      logic [31:0] adr;
      for (int n = 0; n < count; n++) begin
         // Upper bits alias onto the eight words filled earlier
         adr = ($urandom & 32'h7fff_fc00) | (($urandom % 8) << 2);
         run_cycle(port, 1'($urandom), 4'($urandom), adr, $urandom,
                   $sformatf("%s %0d", tag, n));
      end
   endtask

   always @(posedge clk) begin
      while (chk_exp.size() > 0) begin
         check_value(chk_name.pop_front(), chk_exp.pop_front(), chk_act.pop_front());
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("Timeout after %0d cycles, still waiting on:%s%s%s", cycles,
                  busy[0] ? " instruction port" : "", busy[1] ? " data port" : "",
                  busy[2] ? " debug port" : "");
         $display(">>> FAIL");
         $finish;
      end
   end

   initial begin
      logic [31:0] a;
      void'($urandom(32'hed9b6e68));
      reset_i = 1'b1;
      in_fair = 1'b0;
      busy    = '0;
      for (int p = 0; p < 3; p++) begin
         req[p] = '0;
      end
      repeat (4) @(posedge clk);
      #1;
      reset_i = 1'b0;
      repeat (3) begin
         @(negedge clk);
         post_result("idle", 34'h0, {28'h0, bus_rsp[0].ack, bus_rsp[0].err, bus_rsp[1].ack,
                                     bus_rsp[1].err, mam_rsp.ack, mam_rsp.err});
      end
      for (int i = 0; i < 8; i++) begin
         run_cycle(2'd1, 1'b1, 4'hf, i * 4, $urandom, $sformatf("fill %0d", i));
      end
      for (int i = 0; i < 8; i++) begin
         run_cycle(2'd1, 1'b1, sel_pat[i], i * 4, $urandom, $sformatf("byte write %0d", i));
      end
      for (int i = 0; i < 8; i++) begin
         run_cycle(2'd0, 1'b0, 4'hf, i * 4, 32'h0, $sformatf("read %0d", i));
      end
      for (int i = 0; i < 8; i++) begin
         a = (i < 4) ? 32'h400 + i * 4 : 32'h3000_0800 + i * 4;   // Same word index
         run_cycle(2'd0, 1'b0, 4'hf, a, 32'h0, $sformatf("alias read %0d", i));
      end
      for (int i = 0; i < 8; i++) begin
         run_cycle(2'd0, 1'b0, 4'hf, 32'hf000_0000 + i * 4, 32'h0, $sformatf("rom i %0d", i));
         run_cycle(2'd1, 1'b0, 4'hf, 32'hf000_0020 + i * 4, 32'h0, $sformatf("rom d %0d", i));
      end
      run_cycle(2'd1, 1'b1, 4'hf, 32'hf000_0004, 32'hdead_beef, "rom write");
      run_cycle(2'd1, 1'b1, 4'hf, 32'he000_0000, 32'hdead_beef, "na write");
      run_cycle(2'd0, 1'b0, 4'hf, 32'he000_0004, 32'h0, "na read");
      run_cycle(2'd1, 1'b1, 4'hf, 32'h9000_0000, 32'hdead_beef, "unmapped write");
      run_cycle(2'd0, 1'b0, 4'hf, 32'hc000_0008, 32'h0, "unmapped read");
      run_cycle(2'd0, 1'b0, 4'hf, 32'h0, 32'h0, "after unmapped");
      fork
         random_traffic(2'd0, N_RAND, "random i");
         random_traffic(2'd1, N_RAND, "random d");
         random_traffic(2'd2, N_RAND, "random debug");
      join
      in_fair = 1'b1;
      for (int r = 0; r < N_FAIR; r++) begin
         // One master alone, then both request in the same cycle
         random_traffic(2'(r % 2), 1, $sformatf("fair solo %0d", r));
         fork
            random_traffic(2'd0, 1, $sformatf("fair i %0d", r));
            random_traffic(2'd1, 1, $sformatf("fair d %0d", r));
         join
      end
      in_fair = 1'b0;
      for (int k = 1; k < order.size(); k++) begin
         post_result($sformatf("fairness %0d", k), {33'h0, !order[k - 1]}, {33'h0, order[k]});
      end
      post_result("transfer count", 34'(TOTAL), 34'(done_cnt[0] + done_cnt[1] + done_cnt[2]));
      repeat (2) @(posedge clk);
      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* verification/compute_tile_dm_asserts.sv */
// ------------------------------
// Protocol assertions for the bus
// and the SRAM adapter
// ------------------------------
`timescale 1ns/1ps

module compute_tile_dm_asserts (
   input logic                    clk,
   input logic                    reset_i,
   input tile_pkg::wb_req_t [1:0] req_i,     // Two requesters per shared resource
   input tile_pkg::wb_rsp_t [1:0] rsp_i,
   input logic [1:0]              grant_i,
   input logic                    owner_i,
   input logic                    busy_i
);

   a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i) $onehot0(grant_i))
      else $error("Grant is held by more than one requester");

   a_owner_stable: assert property (@(posedge clk) disable iff (reset_i)
      busy_i |=> $stable(owner_i))
      else $error("SRAM owner changed while a cycle was in progress");

   for (genvar i = 0; i < 2; i++) begin : g_port
      a_ack_err: assert property (@(posedge clk) disable iff (reset_i)
         !(rsp_i[i].ack && rsp_i[i].err))
         else $error("Ack and err are high together on requester %0d", i);

      a_rsp_req: assert property (@(posedge clk) disable iff (reset_i)
         (rsp_i[i].ack || rsp_i[i].err) |-> (req_i[i].cyc && req_i[i].stb))
         else $error("Response on requester %0d without an active request", i);
   end

endmodule

bind wb_bus compute_tile_dm_asserts u_bus_asserts (
   .clk     (clk),
   .reset_i (reset_i),
   .req_i   (m_req_i),
   .rsp_i   (m_rsp_o),
   .grant_i (grant),
   .owner_i (1'b0),
   .busy_i  (1'b0)
);

bind mam_wb_adapter compute_tile_dm_asserts u_adapter_asserts (
   .clk     (clk),
   .reset_i (reset_i),
   .req_i   ({wb_mam_req_i, wb_in_req_i}),
   .rsp_i   ({wb_mam_rsp_o, wb_in_rsp_o}),
   .grant_i ({owner_q && busy_q, !owner_q && busy_q}),
   .owner_i (owner_q),
   .busy_i  (wb_out_req_o.cyc)
);

/* hdl/compute_tile_dm.sv */
// ------------------------------
// Compute tile memory system:
// bus, SRAM adapter, SRAM, ROM
// ------------------------------
`timescale 1ns/1ps

module compute_tile_dm (
   input  logic                                         clk,
   input  logic                                         reset_i,
   input  tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] bus_req_i,
   output tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] bus_rsp_o,
   input  tile_pkg::wb_req_t                            mam_req_i,
   output tile_pkg::wb_rsp_t                            mam_rsp_o
);

   tile_pkg::wb_req_t slv_mem_req;
   tile_pkg::wb_rsp_t slv_mem_rsp;
   tile_pkg::wb_req_t slv_rom_req;
   tile_pkg::wb_rsp_t slv_rom_rsp;
   tile_pkg::wb_req_t mem_req;       // Arbitrated SRAM port
   tile_pkg::wb_rsp_t mem_rsp;

   wb_bus u_bus (
      .clk         (clk),
      .reset_i     (reset_i),
      .m_req_i     (bus_req_i),
      .m_rsp_o     (bus_rsp_o),
      .s_mem_req_o (slv_mem_req),
      .s_rom_req_o (slv_rom_req),
      .s_mem_rsp_i (slv_mem_rsp),
      .s_rom_rsp_i (slv_rom_rsp)
   );

   mam_wb_adapter u_mam_wb_adapter (
      .clk          (clk),
      .reset_i      (reset_i),
      .wb_in_req_i  (slv_mem_req),
      .wb_in_rsp_o  (slv_mem_rsp),
      .wb_mam_req_i (mam_req_i),
      .wb_mam_rsp_o (mam_rsp_o),
      .wb_out_req_o (mem_req),
      .wb_out_rsp_i (mem_rsp)
   );

   wb_sram_sp u_ram (
      .clk      (clk),
      .reset_i  (reset_i),
      .wb_req_i (mem_req),
      .wb_rsp_o (mem_rsp)
   );

   bootrom u_bootrom (
      .clk      (clk),
      .reset_i  (reset_i),
      .wb_req_i (slv_rom_req),
      .wb_rsp_o (slv_rom_rsp)
   );

endmodule

/* hdl/bootrom.sv */
// ------------------------------
// Boot ROM slave, read only
// ------------------------------
`timescale 1ns/1ps

module bootrom (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t wb_req_i,
   output tile_pkg::wb_rsp_t wb_rsp_o
);

   logic        access;
   logic        ack_q;
   logic        err_q;
   logic [31:0] rdat_q;

   assign access = wb_req_i.cyc && wb_req_i.stb && !(ack_q || err_q);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access && !wb_req_i.we;
         err_q <= access && wb_req_i.we;            // Writes are refused
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdat_q <= tile_pkg::BOOT_IMAGE[wb_req_i.adr[$clog2(tile_pkg::BOOT_WORDS)+1:2]];
      end
   end

   assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: rdat_q};

endmodule

/* hdl/wb_sram_sp.sv */
// ------------------------------
// Single-port local SRAM with
// byte selects
// ------------------------------
`timescale 1ns/1ps

module wb_sram_sp (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t wb_req_i,
   output tile_pkg::wb_rsp_t wb_rsp_o
);

   logic [31:0]                 mem [tile_pkg::LMEM_WORDS];
   logic [tile_pkg::LMEM_AW-1:0] widx;
   logic                         access;
   logic                         ack_q;
   logic [31:0]                  rdat_q;

   assign widx   = wb_req_i.adr[tile_pkg::LMEM_AW+1:2];   // Aliases above LMEM_WORDS
   assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q; // One ack per request

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (wb_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
               if (wb_req_i.sel[b]) begin
                  mem[widx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
               end
            end
         end
         rdat_q <= mem[widx];                        // Old word on a write
      end
   end

   assign wb_rsp_o = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule

/* hdl/mam_wb_adapter.sv */
// ------------------------------
// Shares the local SRAM between
// the bus and the debug port
// ------------------------------
`timescale 1ns/1ps

module mam_wb_adapter (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t wb_in_req_i,
   output tile_pkg::wb_rsp_t wb_in_rsp_o,
   input  tile_pkg::wb_req_t wb_mam_req_i,
   output tile_pkg::wb_rsp_t wb_mam_rsp_o,
   output tile_pkg::wb_req_t wb_out_req_o,
   input  tile_pkg::wb_rsp_t wb_out_rsp_i
);

   logic              owner_q;   // Set while the debug port owns the SRAM
   logic              busy_q;    // Owner's cycle in progress
   tile_pkg::wb_req_t sel_req;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         owner_q <= 1'b0;
         busy_q  <= 1'b0;
      end else if (!busy_q) begin
         if (wb_mam_req_i.cyc) begin                 // Debug wins a tie
            owner_q <= 1'b1;
            busy_q  <= 1'b1;
         end else if (wb_in_req_i.cyc) begin
            owner_q <= 1'b0;
            busy_q  <= 1'b1;
         end
      end else if (wb_out_rsp_i.ack || wb_out_rsp_i.err || !wb_out_req_o.cyc) begin
         busy_q <= 1'b0;                             // Transfer ended or abandoned
      end
   end

   assign sel_req = owner_q ? wb_mam_req_i : wb_in_req_i;

   always_comb begin
      wb_out_req_o     = sel_req;
      wb_out_req_o.cyc = sel_req.cyc && busy_q;
      wb_out_req_o.stb = sel_req.stb && busy_q;
   end

   // The waiting side sees no ack and keeps holding its request
   assign wb_mam_rsp_o = owner_q ? wb_out_rsp_i : '0;
   assign wb_in_rsp_o  = owner_q ? '0 : wb_out_rsp_i;

endmodule

/* hdl/wb_bus.sv */
// ------------------------------
// Shared Wishbone bus: master mux,
// slave decode, error responder
// ------------------------------
`timescale 1ns/1ps

module wb_bus (
   input  logic                                         clk,
   input  logic                                         reset_i,
   input  tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] m_req_i,
   output tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] m_rsp_o,
   output tile_pkg::wb_req_t                            s_mem_req_o,
   output tile_pkg::wb_req_t                            s_rom_req_o,
   input  tile_pkg::wb_rsp_t                            s_mem_rsp_i,
   input  tile_pkg::wb_rsp_t                            s_rom_rsp_i
);

   logic [tile_pkg::NR_MASTERS-1:0]       m_cyc;
   logic [tile_pkg::NR_MASTERS-1:0]       grant;
   tile_pkg::wb_req_t                     gnt_req;   // Request of the owner
   tile_pkg::wb_rsp_t                     gnt_rsp;
   tile_pkg::slave_e                      slave;
   logic [tile_pkg::REGION_MSB_WIDTH-1:0] region;
   logic                                  err_q;     // Unmapped access responder

   wb_arbiter u_arbiter (
      .clk     (clk),
      .reset_i (reset_i),
      .cyc_i   (m_cyc),
      .grant_o (grant)
   );

   always_comb begin
      gnt_req = '0;
      for (int m = 0; m < tile_pkg::NR_MASTERS; m++) begin
         m_cyc[m] = m_req_i[m].cyc;
         if (grant[m]) begin
            gnt_req = m_req_i[m];
         end
      end
   end

   assign region = gnt_req.adr[31 -: tile_pkg::REGION_MSB_WIDTH];

   always_comb begin
      case (region)
         tile_pkg::ROM_REGION: slave = tile_pkg::SLV_ROM;
         tile_pkg::NA_REGION:  slave = tile_pkg::SLV_NONE;   // No network adapter here
         default: begin
            // Lower half of the address space is local memory
            if (region[tile_pkg::REGION_MSB_WIDTH-1]) begin
               slave = tile_pkg::SLV_NONE;
            end else begin
               slave = tile_pkg::SLV_MEM;
            end
         end
      endcase
   end

   always_comb begin
      s_mem_req_o     = gnt_req;
      s_mem_req_o.cyc = gnt_req.cyc && (slave == tile_pkg::SLV_MEM);
      s_mem_req_o.stb = gnt_req.stb && (slave == tile_pkg::SLV_MEM);
      s_rom_req_o     = gnt_req;
      s_rom_req_o.cyc = gnt_req.cyc && (slave == tile_pkg::SLV_ROM);
      s_rom_req_o.stb = gnt_req.stb && (slave == tile_pkg::SLV_ROM);
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= gnt_req.cyc && gnt_req.stb && (slave == tile_pkg::SLV_NONE) && !err_q;
      end
   end

   always_comb begin
      case (slave)
         tile_pkg::SLV_MEM: gnt_rsp = s_mem_rsp_i;
         tile_pkg::SLV_ROM: gnt_rsp = s_rom_rsp_i;
         default:           gnt_rsp = '{ack: 1'b0, err: err_q, dat: '0};
      endcase
      for (int m = 0; m < tile_pkg::NR_MASTERS; m++) begin
         m_rsp_o[m] = grant[m] ? gnt_rsp : '0;       // Others see an idle bus
      end
   end

endmodule

/* hdl/wb_arbiter.sv */
// ------------------------------
// Round-robin bus arbiter, grant
// held for a whole Wishbone cycle
// ------------------------------
`timescale 1ns/1ps

module wb_arbiter (
   input  logic                            clk,
   input  logic                            reset_i,
   input  logic [tile_pkg::NR_MASTERS-1:0] cyc_i,
   output logic [tile_pkg::NR_MASTERS-1:0] grant_o
);

   logic [tile_pkg::NR_MASTERS-1:0]         grant_q;
   logic [tile_pkg::NR_MASTERS-1:0]         grant_nxt;
   logic [$clog2(tile_pkg::NR_MASTERS)-1:0] last_q;     // Last master served
   logic [$clog2(tile_pkg::NR_MASTERS)-1:0] last_nxt;
   logic                                    owner_busy;

   assign owner_busy = |(grant_q & cyc_i);           // Owner still in its cycle
   assign grant_o    = grant_q;

   always_comb begin
      int idx;
      grant_nxt = grant_q;
      last_nxt  = last_q;
      idx       = 0;
      if (!owner_busy) begin
         grant_nxt = '0;                             // Nobody requests, nobody owns
         // Farthest candidate first so the nearest one after last_q wins
         for (int k = tile_pkg::NR_MASTERS; k >= 1; k--) begin
            idx = (int'(last_q) + k) % tile_pkg::NR_MASTERS;
            if (cyc_i[idx]) begin
               grant_nxt      = '0;
               grant_nxt[idx] = 1'b1;
               last_nxt       = idx[$clog2(tile_pkg::NR_MASTERS)-1:0];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         grant_q <= '0;
         last_q  <= '1;                              // Master 0 goes first
      end else begin
         grant_q <= grant_nxt;
         last_q  <= last_nxt;
      end
   end

endmodule

/* hdl/tile_pkg.sv */
// ------------------------------
// Wishbone request and response
// structs, tile address map and
// boot ROM contents
// ------------------------------

package tile_pkg;

   localparam int NR_MASTERS       = 2;     // Instruction and data port
   localparam int LMEM_WORDS       = 256;
   localparam int LMEM_AW          = 8;     // SRAM word index width
   localparam int REGION_MSB_WIDTH = 4;     // Decoded upper address bits

   localparam logic [REGION_MSB_WIDTH-1:0] ROM_REGION = 4'hf;
   localparam logic [REGION_MSB_WIDTH-1:0] NA_REGION  = 4'he;

   localparam int BOOT_WORDS = 8;

   // Reset stub, sets up r1 and jumps to the SRAM entry at 0x100
   localparam logic [31:0] BOOT_IMAGE [BOOT_WORDS] = '{
      32'h18000000,
      32'ha8200000,
      32'h18400000,
      32'ha8420100,
      32'h44001000,
      32'h15000000,
      32'h00000000,
      32'h15000000
   };

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] adr;
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef enum logic [1:0] {
      SLV_MEM,
      SLV_ROM,
      SLV_NONE
   } slave_e;

endpackage
